// File: include/gpgpu_host_macros.svh
/*
  Widths and AXI-Lite register byte offsets shared by the host glue.
  Offsets are full 8-bit addresses; only word-aligned hits decode.
*/
`ifndef GPGPU_HOST_MACROS_SVH
`define GPGPU_HOST_MACROS_SVH

`define AXIL_ADDR_W      8
`define AXIL_DATA_W      32
`define WG_ID_W          16
`define WF_COUNT_W       4
`define WAVE_ITEM_W      6
`define KERNEL_DIM_W     8
`define MEM_ADDR_W       32
`define AXI_ID_W         4
`define AXI_DATA_W       64

// descriptor registers
`define REG_WG_ID        8'h00
`define REG_NUM_WF       8'h04
`define REG_WF_SIZE      8'h08
`define REG_START_PC     8'h0C
`define REG_KERNEL_SIZE  8'h10 // x 7:0, y 15:8, z 23:16
`define REG_PDS_BASE     8'h14

// control and status
`define REG_LAUNCH       8'h18
`define REG_STATUS       8'h1C // done in bit 0, wg id in 31:16

`endif

// File: hw/gpgpu_host_pkg.sv
/*
  Types for the host-side and memory-side glue of the GPGPU core.
  Channel opcodes cover single-beat put/get and their acks only.
*/
`default_nettype none

`include "gpgpu_host_macros.svh"

package gpgpu_host_pkg;

  typedef logic [`AXIL_ADDR_W-1:0]     axil_addr_t;
  typedef logic [`AXIL_DATA_W-1:0]     axil_data_t;
  typedef logic [`AXIL_DATA_W/8-1:0]   axil_strb_t;

  typedef logic [`WG_ID_W-1:0]         wg_id_t;
  typedef logic [`WF_COUNT_W-1:0]      wf_count_t;
  typedef logic [`WAVE_ITEM_W-1:0]     wave_item_t;
  typedef logic [3*`KERNEL_DIM_W-1:0]  kernel_size_t; // {z, y, x}

  typedef logic [`MEM_ADDR_W-1:0]      mem_addr_t;
  typedef logic [`AXI_ID_W-1:0]        src_id_t;
  typedef logic [`AXI_DATA_W-1:0]      mem_data_t;
  typedef logic [`AXI_DATA_W/8-1:0]    mem_mask_t;

  typedef enum logic [2:0] {
    A_PUT_FULL = 3'd0,
    A_GET      = 3'd4
  } a_opcode_e;

  typedef enum logic [2:0] {
    D_ACCESS_ACK      = 3'd0,
    D_ACCESS_ACK_DATA = 3'd1
  } d_opcode_e;

  typedef enum logic [2:0] {
    BR_IDLE,
    BR_WRITE, // aw and w in flight
    BR_WRESP,
    BR_RADDR,
    BR_RDATA,
    BR_RESP   // channel D valid
  } bridge_state_e;

endpackage

`default_nettype wire

// File: hw/axil_host_regs.sv
/*
  AXI-Lite slave holding one workgroup descriptor. One write and one read
  outstanding; aw and w must arrive together. Descriptor writes are dropped
  while a launch is pending. Reading REG_STATUS clears the done flag.
*/
`default_nettype none

`include "gpgpu_host_macros.svh"

module axil_host_regs import gpgpu_host_pkg::*; (
  input  wire           clk,
  input  wire           rst_n,

  input  wire           s_awvalid_i,
  output logic          s_awready_o,
  input  axil_addr_t    s_awaddr_i,
  input  wire           s_wvalid_i,
  output logic          s_wready_o,
  input  axil_data_t    s_wdata_i,
  input  axil_strb_t    s_wstrb_i,
  output logic          s_bvalid_o,
  input  wire           s_bready_i,
  output logic [1:0]    s_bresp_o,

  input  wire           s_arvalid_i,
  output logic          s_arready_o,
  input  axil_addr_t    s_araddr_i,
  output logic          s_rvalid_o,
  input  wire           s_rready_i,
  output axil_data_t    s_rdata_o,
  output logic [1:0]    s_rresp_o,

  input  wire           launch_pending_i,
  input  wire           done_i,
  input  wg_id_t        done_wg_id_i,
  output logic          launch_o,
  output logic          status_rd_o,

  output wg_id_t        wg_id_o,
  output wf_count_t     num_wf_o,
  output wave_item_t    wf_size_o,
  output mem_addr_t     start_pc_o,
  output kernel_size_t  kernel_size_o,
  output mem_addr_t     pds_baseaddr_o
);

  logic       wr_fire;
  logic       rd_fire;
  logic       desc_wr;
  axil_data_t wr_cur;
  axil_data_t wr_val;
  axil_data_t rd_mux;

  function automatic axil_data_t strb_merge(axil_data_t old_val, axil_data_t new_val,
                                            axil_strb_t strb);
    axil_data_t res;
    res = old_val;
    for (int i = 0; i < `AXIL_DATA_W/8; i++) begin
      if (strb[i])
        res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  // both channels taken in one cycle
  assign wr_fire     = s_awvalid_i & s_wvalid_i & ~s_bvalid_o;
  assign s_awready_o = wr_fire;
  assign s_wready_o  = wr_fire;
  assign s_bresp_o   = 2'b00;
  assign desc_wr     = wr_fire & ~launch_pending_i;
  assign launch_o    = desc_wr & (s_awaddr_i == `REG_LAUNCH);

  assign s_arready_o = ~s_rvalid_o;
  assign rd_fire     = s_arvalid_i & s_arready_o;
  assign s_rresp_o   = 2'b00;
  assign status_rd_o = rd_fire & (s_araddr_i == `REG_STATUS);

  // current register value for the byte merge
  always_comb begin
    wr_cur = '0;
    case (s_awaddr_i)
      `REG_WG_ID:       wr_cur[`WG_ID_W-1:0]        = wg_id_o;
      `REG_NUM_WF:      wr_cur[`WF_COUNT_W-1:0]     = num_wf_o;
      `REG_WF_SIZE:     wr_cur[`WAVE_ITEM_W-1:0]    = wf_size_o;
      `REG_START_PC:    wr_cur[`MEM_ADDR_W-1:0]     = start_pc_o;
      `REG_KERNEL_SIZE: wr_cur[3*`KERNEL_DIM_W-1:0] = kernel_size_o;
      `REG_PDS_BASE:    wr_cur[`MEM_ADDR_W-1:0]     = pds_baseaddr_o;
      default: ;
    endcase
  end

  assign wr_val = strb_merge(wr_cur, s_wdata_i, s_wstrb_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wg_id_o        <= '0;
      num_wf_o       <= '0;
      wf_size_o      <= '0;
      start_pc_o     <= '0;
      kernel_size_o  <= '0;
      pds_baseaddr_o <= '0;
    end else if (desc_wr) begin
      case (s_awaddr_i)
        `REG_WG_ID:       wg_id_o        <= wr_val[`WG_ID_W-1:0];
        `REG_NUM_WF:      num_wf_o       <= wr_val[`WF_COUNT_W-1:0];
        `REG_WF_SIZE:     wf_size_o      <= wr_val[`WAVE_ITEM_W-1:0];
        `REG_START_PC:    start_pc_o     <= wr_val[`MEM_ADDR_W-1:0];
        `REG_KERNEL_SIZE: kernel_size_o  <= wr_val[3*`KERNEL_DIM_W-1:0];
        `REG_PDS_BASE:    pds_baseaddr_o <= wr_val[`MEM_ADDR_W-1:0];
        default: ; // launch and unmapped
      endcase
    end
  end

  always_comb begin
    rd_mux = '0;
    case (s_araddr_i)
      `REG_WG_ID:       rd_mux[`WG_ID_W-1:0]        = wg_id_o;
      `REG_NUM_WF:      rd_mux[`WF_COUNT_W-1:0]     = num_wf_o;
      `REG_WF_SIZE:     rd_mux[`WAVE_ITEM_W-1:0]    = wf_size_o;
      `REG_START_PC:    rd_mux[`MEM_ADDR_W-1:0]     = start_pc_o;
      `REG_KERNEL_SIZE: rd_mux[3*`KERNEL_DIM_W-1:0] = kernel_size_o;
      `REG_PDS_BASE:    rd_mux[`MEM_ADDR_W-1:0]     = pds_baseaddr_o;
      `REG_LAUNCH:      rd_mux[0]                   = launch_pending_i;
      `REG_STATUS: begin
        rd_mux[0]                          = done_i;
        rd_mux[`AXIL_DATA_W-1 -: `WG_ID_W] = done_wg_id_i;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_bvalid_o <= 1'b0;
      s_rvalid_o <= 1'b0;
    end else begin
      if (wr_fire)
        s_bvalid_o <= 1'b1;
      else if (s_bready_i)
        s_bvalid_o <= 1'b0;
      if (rd_fire)
        s_rvalid_o <= 1'b1;
      else if (s_rready_i)
        s_rvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire)
      s_rdata_o <= rd_mux; // held until rready
  end

endmodule

`default_nettype wire

// File: hw/wg_launch_ctrl.sv
/*
  Launch and completion tracking for one workgroup at a time.
  A new completion is refused until software reads the status register.
*/
`default_nettype none

module wg_launch_ctrl import gpgpu_host_pkg::*; (
  input  wire    clk,
  input  wire    rst_n,

  input  wire    launch_i,
  input  wire    status_rd_i,
  output logic   launch_pending_o,
  output logic   done_o,
  output wg_id_t done_wg_id_o,

  output logic   host_req_valid_o,
  input  wire    host_req_ready_i,

  input  wire    host_rsp_valid_i,
  output logic   host_rsp_ready_o,
  input  wg_id_t host_rsp_wg_id_i
);

  logic rsp_fire;

  assign launch_pending_o = host_req_valid_o; // pending until core takes it
  assign host_rsp_ready_o = ~done_o;
  assign rsp_fire         = host_rsp_valid_i & host_rsp_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      host_req_valid_o <= 1'b0;
    end else if (launch_i) begin
      host_req_valid_o <= 1'b1;
    end else if (host_req_ready_i) begin
      host_req_valid_o <= 1'b0;
    end
  end

  // set wins so a completion is never lost to a status read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_o       <= 1'b0;
      done_wg_id_o <= '0;
    end else if (rsp_fire) begin
      done_o       <= 1'b1;
      done_wg_id_o <= host_rsp_wg_id_i;
    end else if (status_rd_i) begin
      done_o       <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hw/mem_axi_bridge.sv
/*
  Channel A/D to AXI4 master, single-beat 64-bit put and get only.
  One request in flight; a_ready is low from accept until the D handshake.
  Any opcode other than get is issued as a write. bresp/rresp are ignored.
*/
`default_nettype none

module mem_axi_bridge import gpgpu_host_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,

  input  wire        a_valid_i,
  output logic       a_ready_o,
  input  a_opcode_e  a_opcode_i,
  input  src_id_t    a_source_i,
  input  mem_addr_t  a_address_i,
  input  mem_mask_t  a_mask_i,
  input  mem_data_t  a_data_i,

  output logic       d_valid_o,
  input  wire        d_ready_i,
  output d_opcode_e  d_opcode_o,
  output src_id_t    d_source_o,
  output mem_data_t  d_data_o,

  output logic       m_awvalid_o,
  input  wire        m_awready_i,
  output src_id_t    m_awid_o,
  output mem_addr_t  m_awaddr_o,
  output logic       m_wvalid_o,
  input  wire        m_wready_i,
  output mem_data_t  m_wdata_o,
  output mem_mask_t  m_wstrb_o,
  input  wire        m_bvalid_i,
  output logic       m_bready_o,
  input  src_id_t    m_bid_i,

  output logic       m_arvalid_o,
  input  wire        m_arready_i,
  output src_id_t    m_arid_o,
  output mem_addr_t  m_araddr_o,
  input  wire        m_rvalid_i,
  output logic       m_rready_o,
  input  src_id_t    m_rid_i,
  input  mem_data_t  m_rdata_i
);

  bridge_state_e state_q;
  logic          aw_done_q;
  logic          w_done_q;
  logic          aw_done_nxt;
  logic          w_done_nxt;
  logic          a_fire;
  src_id_t       req_src_q;
  mem_addr_t     req_addr_q;
  mem_data_t     req_data_q;
  mem_mask_t     req_mask_q;

  assign a_ready_o   = (state_q == BR_IDLE);
  assign a_fire      = a_valid_i & a_ready_o;

  assign m_awvalid_o = (state_q == BR_WRITE) & ~aw_done_q;
  assign m_wvalid_o  = (state_q == BR_WRITE) & ~w_done_q;
  assign m_bready_o  = (state_q == BR_WRESP);
  assign m_arvalid_o = (state_q == BR_RADDR);
  assign m_rready_o  = (state_q == BR_RDATA);
  assign d_valid_o   = (state_q == BR_RESP);

  assign aw_done_nxt = aw_done_q | (m_awvalid_o & m_awready_i);
  assign w_done_nxt  = w_done_q | (m_wvalid_o & m_wready_i);

  assign m_awid_o    = req_src_q;
  assign m_awaddr_o  = req_addr_q;
  assign m_wdata_o   = req_data_q;
  assign m_wstrb_o   = req_mask_q;
  assign m_arid_o    = req_src_q;
  assign m_araddr_o  = req_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= BR_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      case (state_q)
        BR_IDLE: begin
          if (a_fire)
            state_q <= (a_opcode_i == A_GET) ? BR_RADDR : BR_WRITE;
        end
        BR_WRITE: begin
          if (aw_done_nxt && w_done_nxt) begin
            state_q   <= BR_WRESP;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end else begin
            aw_done_q <= aw_done_nxt;
            w_done_q  <= w_done_nxt;
          end
        end
        BR_WRESP: if (m_bvalid_i)  state_q <= BR_RESP;
        BR_RADDR: if (m_arready_i) state_q <= BR_RDATA;
        BR_RDATA: if (m_rvalid_i)  state_q <= BR_RESP;
        BR_RESP:  if (d_ready_i)   state_q <= BR_IDLE;
        default:  state_q <= BR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (a_fire) begin
      req_src_q  <= a_source_i;
      req_addr_q <= a_address_i;
      req_data_q <= a_data_i;
      req_mask_q <= a_mask_i;
    end
    if ((state_q == BR_WRESP) && m_bvalid_i) begin
      d_opcode_o <= D_ACCESS_ACK;
      d_source_o <= m_bid_i;
      d_data_o   <= '0; // no payload on write ack
    end
    if ((state_q == BR_RDATA) && m_rvalid_i) begin
      d_opcode_o <= D_ACCESS_ACK_DATA;
      d_source_o <= m_rid_i;
      d_data_o   <= m_rdata_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/gpgpu_host_top.sv
/*
  Host and memory glue around the GPGPU core, which sits outside.
  Constant AXI fields (len, size, burst and the rest) are tied off by the
  integrator to single-beat, 8-byte, INCR.
*/
`default_nettype none

module gpgpu_host_top import gpgpu_host_pkg::*; (
  input  wire           clk,
  input  wire           rst_n,

  input  wire           s_awvalid_i,
  output logic          s_awready_o,
  input  axil_addr_t    s_awaddr_i,
  input  wire           s_wvalid_i,
  output logic          s_wready_o,
  input  axil_data_t    s_wdata_i,
  input  axil_strb_t    s_wstrb_i,
  output logic          s_bvalid_o,
  input  wire           s_bready_i,
  output logic [1:0]    s_bresp_o,
  input  wire           s_arvalid_i,
  output logic          s_arready_o,
  input  axil_addr_t    s_araddr_i,
  output logic          s_rvalid_o,
  input  wire           s_rready_i,
  output axil_data_t    s_rdata_o,
  output logic [1:0]    s_rresp_o,

  output logic          host_req_valid_o,
  input  wire           host_req_ready_i,
  output wg_id_t        host_req_wg_id_o,
  output wf_count_t     host_req_num_wf_o,
  output wave_item_t    host_req_wf_size_o,
  output mem_addr_t     host_req_start_pc_o,
  output kernel_size_t  host_req_kernel_size_o,
  output mem_addr_t     host_req_pds_baseaddr_o,
  input  wire           host_rsp_valid_i,
  output logic          host_rsp_ready_o,
  input  wg_id_t        host_rsp_wg_id_i,

  input  wire           a_valid_i,
  output logic          a_ready_o,
  input  a_opcode_e     a_opcode_i,
  input  src_id_t       a_source_i,
  input  mem_addr_t     a_address_i,
  input  mem_mask_t     a_mask_i,
  input  mem_data_t     a_data_i,
  output logic          d_valid_o,
  input  wire           d_ready_i,
  output d_opcode_e     d_opcode_o,
  output src_id_t       d_source_o,
  output mem_data_t     d_data_o,

  output logic          m_awvalid_o,
  input  wire           m_awready_i,
  output src_id_t       m_awid_o,
  output mem_addr_t     m_awaddr_o,
  output logic          m_wvalid_o,
  input  wire           m_wready_i,
  output mem_data_t     m_wdata_o,
  output mem_mask_t     m_wstrb_o,
  input  wire           m_bvalid_i,
  output logic          m_bready_o,
  input  src_id_t       m_bid_i,
  output logic          m_arvalid_o,
  input  wire           m_arready_i,
  output src_id_t       m_arid_o,
  output mem_addr_t     m_araddr_o,
  input  wire           m_rvalid_i,
  output logic          m_rready_o,
  input  src_id_t       m_rid_i,
  input  mem_data_t     m_rdata_i
);

  logic   launch;
  logic   status_rd;
  logic   launch_pending;
  logic   done;
  wg_id_t done_wg_id;

  axil_host_regs u_regs (
    .launch_o         (launch),
    .status_rd_o      (status_rd),
    .launch_pending_i (launch_pending),
    .done_i           (done),
    .done_wg_id_i     (done_wg_id),
    .wg_id_o          (host_req_wg_id_o),
    .num_wf_o         (host_req_num_wf_o),
    .wf_size_o        (host_req_wf_size_o),
    .start_pc_o       (host_req_start_pc_o),
    .kernel_size_o    (host_req_kernel_size_o),
    .pds_baseaddr_o   (host_req_pds_baseaddr_o),
    .*
  );

  wg_launch_ctrl u_launch (
    .launch_i         (launch),
    .status_rd_i      (status_rd),
    .launch_pending_o (launch_pending),
    .done_o           (done),
    .done_wg_id_o     (done_wg_id),
    .*
  );

  mem_axi_bridge u_bridge (.*); // ports match the top names

endmodule

`default_nettype wire

// File: tests/tb_axi_mem_model.sv
/*
  Single-beat AXI4 slave for simulation, no storage behind it.
  aw and w are taken independently after 0-3 cycle random waits.
  Reads return {~araddr, araddr}; bid and rid echo awid and arid.
*/
`default_nettype none

module tb_axi_mem_model import gpgpu_host_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire [9:0]  rnd_i,       // 2 bits of wait per channel

  input  wire        awvalid_i,
  output logic       awready_o,
  input  src_id_t    awid_i,
  input  wire        wvalid_i,
  output logic       wready_o,
  output logic       bvalid_o,
  input  wire        bready_i,
  output src_id_t    bid_o,

  input  wire        arvalid_i,
  output logic       arready_o,
  input  src_id_t    arid_i,
  input  mem_addr_t  araddr_i,
  output logic       rvalid_o,
  input  wire        rready_i,
  output src_id_t    rid_o,
  output mem_data_t  rdata_o
);

  logic [1:0] aw_wait;
  logic [1:0] w_wait;
  logic [1:0] b_wait;
  logic [1:0] ar_wait;
  logic [1:0] r_wait;
  logic       aw_got;
  logic       w_got;
  logic       ar_got;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      {awready_o, wready_o, bvalid_o, arready_o, rvalid_o} <= '0;
      {aw_got, w_got, ar_got} <= '0;
      {aw_wait, w_wait, b_wait, ar_wait, r_wait} <= '0;
      bid_o   <= '0;
      rid_o   <= '0;
      rdata_o <= '0;
    end else begin
      if (awvalid_i && awready_o) begin
        awready_o <= 1'b0;
        aw_got    <= 1'b1;
        bid_o     <= awid_i;
      end else if (awvalid_i && !aw_got) begin
        if (aw_wait == 2'd0)
          awready_o <= 1'b1;
        else
          aw_wait <= aw_wait - 2'd1;
      end else if (!awvalid_i) begin
        aw_wait <= rnd_i[1:0];
      end

      if (wvalid_i && wready_o) begin
        wready_o <= 1'b0;
        w_got    <= 1'b1;
      end else if (wvalid_i && !w_got) begin
        if (w_wait == 2'd0)
          wready_o <= 1'b1;
        else
          w_wait <= w_wait - 2'd1;
      end else if (!wvalid_i) begin
        w_wait <= rnd_i[3:2];
      end

      if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
        aw_got   <= 1'b0;
        w_got    <= 1'b0;
      end else if (aw_got && w_got && !bvalid_o) begin
        if (b_wait == 2'd0)
          bvalid_o <= 1'b1;
        else
          b_wait <= b_wait - 2'd1;
      end else if (!bvalid_o) begin
        b_wait <= rnd_i[5:4];
      end

      if (arvalid_i && arready_o) begin
        arready_o <= 1'b0;
        ar_got    <= 1'b1;
        rid_o     <= arid_i;
        rdata_o   <= {~araddr_i, araddr_i};
      end else if (arvalid_i && !ar_got) begin
        if (ar_wait == 2'd0)
          arready_o <= 1'b1;
        else
          ar_wait <= ar_wait - 2'd1;
      end else if (!arvalid_i) begin
        ar_wait <= rnd_i[7:6];
      end

      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
        ar_got   <= 1'b0;
      end else if (ar_got && !rvalid_o) begin
        if (r_wait == 2'd0)
          rvalid_o <= 1'b1;
        else
          r_wait <= r_wait - 2'd1;
      end else if (!rvalid_o) begin
        r_wait <= rnd_i[9:8];
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_gpgpu_host.sv
/*
  Drives the AXI-Lite, host and channel A ports of gpgpu_host_top.
  Expected values come from a register, launch and channel model kept here.
  The AXI side is served by tb_axi_mem_model. Fixed-seed LFSR stimulus.
*/
`default_nettype none

`include "gpgpu_host_macros.svh"

module tb_gpgpu_host import gpgpu_host_pkg::*;;

  localparam int CLK_PERIOD    = 20;
  localparam logic [15:0] SEED = 16'd28595;
  localparam int NUM_REG_OPS   = 24;
  localparam int NUM_LAUNCHES  = 2;
  localparam int NUM_RSPS      = 3;
  localparam int NUM_MEM_PAIRS = 8;
  localparam int NUM_OPS = 2*NUM_REG_OPS + 4 + 8*NUM_LAUNCHES + 3*NUM_RSPS + 2*NUM_MEM_PAIRS;
  localparam axil_data_t FIELD_MASK [0:5] = '{32'h0000_FFFF, 32'h0000_000F,
    32'h0000_003F, 32'hFFFF_FFFF, 32'h00FF_FFFF, 32'hFFFF_FFFF};

  logic clk = 1'b0;
  logic rst_n;
  logic s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o, s_bvalid_o, s_bready_i;
  logic s_arvalid_i, s_arready_o, s_rvalid_o, s_rready_i;
  axil_addr_t s_awaddr_i, s_araddr_i;
  axil_data_t s_wdata_i, s_rdata_o;
  axil_strb_t s_wstrb_i;
  logic [1:0] s_bresp_o, s_rresp_o;
  logic host_req_valid_o, host_req_ready_i, host_rsp_valid_i, host_rsp_ready_o;
  wg_id_t host_req_wg_id_o, host_rsp_wg_id_i;
  wf_count_t host_req_num_wf_o;
  wave_item_t host_req_wf_size_o;
  mem_addr_t host_req_start_pc_o, host_req_pds_baseaddr_o;
  kernel_size_t host_req_kernel_size_o;
  logic a_valid_i, a_ready_o, d_valid_o, d_ready_i;
  a_opcode_e a_opcode_i;
  d_opcode_e d_opcode_o;
  src_id_t a_source_i, d_source_o;
  mem_addr_t a_address_i;
  mem_mask_t a_mask_i;
  mem_data_t a_data_i, d_data_o;
  logic m_awvalid_o, m_awready_i, m_wvalid_o, m_wready_i, m_bvalid_i, m_bready_o;
  logic m_arvalid_o, m_arready_i, m_rvalid_i, m_rready_o;
  src_id_t m_awid_o, m_bid_i, m_arid_o, m_rid_i;
  mem_addr_t m_awaddr_o, m_araddr_o;
  mem_data_t m_wdata_o, m_rdata_i;
  mem_mask_t m_wstrb_o;

  logic [15:0] stim_lfsr = SEED;
  logic [15:0] bg_lfsr = SEED;
  logic [9:0]  mem_rnd;
  logic        req_ready_en;

  // reference model state
  axil_data_t reg_model [0:5];
  axil_data_t exp_rd;
  logic       pending_exp;
  logic       done_exp;
  wg_id_t     done_id_exp;
  logic       busy_exp;
  a_opcode_e  exp_op;
  src_id_t    exp_src;
  mem_addr_t  exp_addr;
  mem_mask_t  exp_mask;
  mem_data_t  exp_data;
  logic [113:0] exp_fields;

  gpgpu_host_top dut (.*);

  tb_axi_mem_model mem_model (
    .clk, .rst_n, .rnd_i(mem_rnd),
    .awvalid_i(m_awvalid_o), .awready_o(m_awready_i), .awid_i(m_awid_o),
    .wvalid_i(m_wvalid_o), .wready_o(m_wready_i),
    .bvalid_o(m_bvalid_i), .bready_i(m_bready_o), .bid_o(m_bid_i),
    .arvalid_i(m_arvalid_o), .arready_o(m_arready_i), .arid_i(m_arid_o),
    .araddr_i(m_araddr_o),
    .rvalid_o(m_rvalid_i), .rready_i(m_rready_o), .rid_o(m_rid_i), .rdata_o(m_rdata_i)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 16'hB400;
    return n;
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      val[i] = stim_lfsr[0];
      stim_lfsr = lfsr_step(stim_lfsr);
    end
  endtask

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
    stop_with_error($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  function automatic axil_data_t model_read(input axil_addr_t addr);
    axil_data_t v;
    v = '0;
    if (addr[1:0] == 2'b00 && addr < `REG_LAUNCH)
      v = reg_model[addr[4:2]];
    else if (addr == `REG_LAUNCH)
      v[0] = pending_exp;
    else if (addr == `REG_STATUS)
      v = {done_id_exp, 15'd0, done_exp};
    return v;
  endfunction

  // descriptor fields in host_req port order
  assign exp_fields = {reg_model[0][15:0], reg_model[1][3:0], reg_model[2][5:0], reg_model[3],
                       reg_model[4][23:0], reg_model[5]};

  function automatic logic [70:0] model_d();
    if (exp_op == A_GET)
      return {D_ACCESS_ACK_DATA, exp_src, ~exp_addr, exp_addr};
    return {D_ACCESS_ACK, exp_src, 64'd0};
  endfunction

  // back-pressure and memory model waits
  always @(posedge clk) begin : bg_random
    logic [11:0] bits;
    int k;
    for (k = 0; k < 12; k++) begin
      bits[k] = bg_lfsr[0];
      bg_lfsr = lfsr_step(bg_lfsr);
    end
    mem_rnd          <= bits[9:0];
    host_req_ready_i <= req_ready_en & bits[10];
    d_ready_i        <= bits[11];
  end

  always @(posedge clk) begin : model_update
    axil_data_t nv;
    int b;
    if (s_awvalid_i && s_awready_o && !pending_exp) begin
      if (s_awaddr_i == `REG_LAUNCH) begin
        pending_exp <= 1'b1;
      end else if (s_awaddr_i[1:0] == 2'b00 && s_awaddr_i < `REG_LAUNCH) begin
        nv = reg_model[s_awaddr_i[4:2]];
        for (b = 0; b < 4; b++) begin
          if (s_wstrb_i[b])
            nv[8*b +: 8] = s_wdata_i[8*b +: 8];
        end
        reg_model[s_awaddr_i[4:2]] <= nv & FIELD_MASK[s_awaddr_i[4:2]];
      end
    end
    if (pending_exp && host_req_ready_i)
      pending_exp <= 1'b0;
    if (host_rsp_valid_i && !done_exp) begin
      done_exp    <= 1'b1;
      done_id_exp <= host_rsp_wg_id_i;
    end else if (s_arvalid_i && s_arready_o && s_araddr_i == `REG_STATUS) begin
      done_exp <= 1'b0;
    end
    if (s_arvalid_i && s_arready_o)
      exp_rd <= model_read(s_araddr_i);
    if (a_valid_i && !busy_exp) begin
      busy_exp <= 1'b1;
      exp_op   <= a_opcode_i;
      exp_src  <= a_source_i;
      exp_addr <= a_address_i;
      exp_mask <= a_mask_i;
      exp_data <= a_data_i;
    end else if (d_valid_o && d_ready_i) begin
      busy_exp <= 1'b0;
    end
  end

  aw_ready_chk: assert property (@(posedge clk) disable iff (!rst_n)
    {s_awready_o, s_wready_o} == {2{s_awvalid_i && s_wvalid_i && !s_bvalid_o}})
    else value_mismatch("s_awready_o/s_wready_o", $sampled({s_awready_o, s_wready_o}),
      {2{$sampled(s_awvalid_i && s_wvalid_i && !s_bvalid_o)}});
  ar_ready_chk: assert property (@(posedge clk) disable iff (!rst_n)
    s_arready_o == !s_rvalid_o)
    else value_mismatch("s_arready_o", $sampled(s_arready_o), $sampled(!s_rvalid_o));
  resp_chk: assert property (@(posedge clk) disable iff (!rst_n) {s_bresp_o, s_rresp_o} == 4'd0)
    else value_mismatch("s_bresp_o/s_rresp_o", $sampled({s_bresp_o, s_rresp_o}), 0);
  b_hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o)
    else stop_with_error("bvalid dropped before bready");
  r_hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o))
    else stop_with_error("rvalid or rdata changed before rready");
  rdata_chk: assert property (@(posedge clk) disable iff (!rst_n) s_rvalid_o |-> s_rdata_o == exp_rd)
    else value_mismatch("s_rdata_o", $sampled(s_rdata_o), $sampled(exp_rd));
  fields_chk: assert property (@(posedge clk) disable iff (!rst_n)
    {host_req_wg_id_o, host_req_num_wf_o, host_req_wf_size_o, host_req_start_pc_o,
     host_req_kernel_size_o, host_req_pds_baseaddr_o} == exp_fields)
    else value_mismatch("host_req fields", $sampled({host_req_wg_id_o, host_req_num_wf_o,
      host_req_wf_size_o, host_req_start_pc_o, host_req_kernel_size_o,
      host_req_pds_baseaddr_o}), $sampled(exp_fields));
  req_valid_chk: assert property (@(posedge clk) disable iff (!rst_n)
    host_req_valid_o == pending_exp)
    else value_mismatch("host_req_valid_o", $sampled(host_req_valid_o), $sampled(pending_exp));
  rsp_ready_chk: assert property (@(posedge clk) disable iff (!rst_n)
    host_rsp_ready_o == !done_exp)
    else value_mismatch("host_rsp_ready_o", $sampled(host_rsp_ready_o), $sampled(!done_exp));
  a_ready_chk: assert property (@(posedge clk) disable iff (!rst_n) a_ready_o == !busy_exp)
    else value_mismatch("a_ready_o", $sampled(a_ready_o), $sampled(!busy_exp));
  aw_chk: assert property (@(posedge clk) disable iff (!rst_n)
    m_awvalid_o |-> {m_awid_o, m_awaddr_o} == {exp_src, exp_addr})
    else value_mismatch("m_awid_o/m_awaddr_o", $sampled({m_awid_o, m_awaddr_o}),
      {exp_src, exp_addr});
  w_chk: assert property (@(posedge clk) disable iff (!rst_n)
    m_wvalid_o |-> {m_wstrb_o, m_wdata_o} == {exp_mask, exp_data})
    else value_mismatch("m_wstrb_o/m_wdata_o", $sampled({m_wstrb_o, m_wdata_o}),
      {exp_mask, exp_data});
  ar_chk: assert property (@(posedge clk) disable iff (!rst_n)
    m_arvalid_o |-> {m_arid_o, m_araddr_o} == {exp_src, exp_addr})
    else value_mismatch("m_arid_o/m_araddr_o", $sampled({m_arid_o, m_araddr_o}),
      {exp_src, exp_addr});
  d_chk: assert property (@(posedge clk) disable iff (!rst_n)
    d_valid_o |-> {d_opcode_o, d_source_o, d_data_o} == model_d())
    else value_mismatch("d_opcode_o/d_source_o/d_data_o",
      $sampled({d_opcode_o, d_source_o, d_data_o}), model_d());
  d_hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
    d_valid_o && !d_ready_i |=> d_valid_o && $stable({d_opcode_o, d_source_o, d_data_o}))
    else stop_with_error("channel D valid or fields changed before d_ready");

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb);
    logic [31:0] dly;
    @(posedge clk);
    s_awvalid_i <= 1'b1;
    s_awaddr_i  <= addr;
    s_wvalid_i  <= 1'b1;
    s_wdata_i   <= data;
    s_wstrb_i   <= strb;
    @(negedge clk);
    while (!s_awready_o) @(negedge clk);
    @(posedge clk);
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
    rand_bits(2, dly);
    repeat (dly) @(posedge clk);
    s_bready_i <= 1'b1;
    @(negedge clk);
    while (!s_bvalid_o) @(negedge clk);
    @(posedge clk);
    s_bready_i <= 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr);
    logic [31:0] dly;
    @(posedge clk);
    s_arvalid_i <= 1'b1;
    s_araddr_i  <= addr;
    @(negedge clk);
    while (!s_arready_o) @(negedge clk);
    @(posedge clk);
    s_arvalid_i <= 1'b0;
    rand_bits(2, dly);
    repeat (dly) @(posedge clk);
    s_rready_i <= 1'b1;
    @(negedge clk);
    while (!s_rvalid_o) @(negedge clk);
    @(posedge clk);
    s_rready_i <= 1'b0;
  endtask

  task automatic mem_access(input a_opcode_e op, input src_id_t src, input mem_addr_t addr,
                            input mem_mask_t mask, input mem_data_t data);
    @(posedge clk);
    a_valid_i   <= 1'b1;
    a_opcode_i  <= op;
    a_source_i  <= src;
    a_address_i <= addr;
    a_mask_i    <= mask;
    a_data_i    <= data;
    @(negedge clk);
    while (!a_ready_o) @(negedge clk);
    @(posedge clk);
    a_valid_i <= 1'b0;
    @(negedge clk);
    while (!(d_valid_o && d_ready_i)) @(negedge clk);
    @(posedge clk);
  endtask

  initial begin : watchdog
    #(NUM_OPS * 40 * CLK_PERIOD);
    stop_with_error("watchdog timeout, the tests did not finish in time");
  end

  initial begin : main
    logic [31:0] r;
    logic [31:0] r2;
    int i;
    rst_n = 1'b0;
    {s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i} = '0;
    s_awaddr_i = '0;
    s_araddr_i = '0;
    s_wdata_i = '0;
    s_wstrb_i = '0;
    {host_req_ready_i, host_rsp_valid_i, a_valid_i, d_ready_i, req_ready_en} = '0;
    host_rsp_wg_id_i = '0;
    a_opcode_i = A_PUT_FULL;
    a_source_i = '0;
    a_address_i = '0;
    a_mask_i = '0;
    a_data_i = '0;
    mem_rnd = '0;
    for (i = 0; i < 6; i++)
      reg_model[i] = '0;
    {pending_exp, done_exp, busy_exp} = '0;
    done_id_exp = '0;
    exp_rd = '0;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert ({s_bvalid_o, s_rvalid_o, host_req_valid_o, m_awvalid_o, m_wvalid_o, m_arvalid_o,
             m_bready_o, m_rready_o, d_valid_o, host_rsp_ready_o, a_ready_o} == 11'b11)
      else value_mismatch("outputs after reset", {s_bvalid_o, s_rvalid_o, host_req_valid_o,
        m_awvalid_o, m_wvalid_o, m_arvalid_o, m_bready_o, m_rready_o, d_valid_o,
        host_rsp_ready_o, a_ready_o}, 11'b11);

    for (i = 0; i < NUM_REG_OPS; i++) begin
      rand_bits(3, r);
      rand_bits(32, r2);
      axil_write(axil_addr_t'((r % 6) * 4), r2, r[2:0] ^ axil_strb_t'(i));
      axil_read(axil_addr_t'((r % 6) * 4));
    end
    axil_write(8'h20, 32'hFFFF_FFFF, 4'hF); // unmapped, dropped
    axil_read(8'h20);
    axil_read(`REG_LAUNCH);
    axil_read(`REG_STATUS);

    for (i = 0; i < NUM_LAUNCHES; i++) begin
      req_ready_en <= 1'b0;
      rand_bits(32, r);
      axil_write(`REG_WG_ID, r, 4'hF);
      axil_write(`REG_LAUNCH, 32'd1, 4'hF);
      axil_read(`REG_LAUNCH);
      rand_bits(32, r);
      axil_write(`REG_START_PC, r, 4'hF); // ignored while pending
      axil_write(`REG_WG_ID, ~r, 4'h3);
      axil_read(`REG_START_PC);
      req_ready_en <= 1'b1;
      @(negedge clk);
      while (host_req_valid_o) @(negedge clk);
      axil_read(`REG_LAUNCH);
    end

    for (i = 0; i < NUM_RSPS; i++) begin
      rand_bits(16, r);
      @(posedge clk);
      host_rsp_valid_i <= 1'b1;
      host_rsp_wg_id_i <= r[15:0];
      @(negedge clk);
      while (!host_rsp_ready_o) @(negedge clk);
      @(posedge clk);
      host_rsp_wg_id_i <= ~r[15:0]; // refused while done is set
      repeat (3) @(posedge clk);
      host_rsp_valid_i <= 1'b0;
      axil_read(`REG_STATUS);
      axil_read(`REG_STATUS);
    end

    for (i = 0; i < NUM_MEM_PAIRS; i++) begin
      rand_bits(32, r);
      rand_bits(32, r2);
      mem_access(A_PUT_FULL, src_id_t'(r2[3:0]), {r[31:3], 3'b000}, r2[11:4],
                 {~r2, r2 ^ r});
      rand_bits(4, r2);
      mem_access(A_GET, src_id_t'(r2[3:0]), {r[31:3], 3'b000}, 8'hFF, '0);
    end

    repeat (4) @(posedge clk);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
hw/gpgpu_host_pkg.sv
hw/axil_host_regs.sv
hw/wg_launch_ctrl.sv
hw/mem_axi_bridge.sv
hw/gpgpu_host_top.sv
tests/tb_axi_mem_model.sv
tests/tb_gpgpu_host.sv
